/* files.f */
hdl/mac_cfg_pkg.sv
hdl/mac_state_pkg.sv
hdl/mac_csr.sv
hdl/mac_rx_slot.sv
hdl/mac_rx_sel.sv
hdl/mac_rx_dma.sv
hdl/mac_top.sv
bench/mac_asserts.sv
bench/mac_tb.sv

/* Makefile */
# Verilator flow for the receive MAC.

RTL = hdl/mac_cfg_pkg.sv hdl/mac_state_pkg.sv hdl/mac_csr.sv hdl/mac_rx_slot.sv \
      hdl/mac_rx_sel.sv hdl/mac_rx_dma.sv hdl/mac_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module mac_top $(RTL)

sim:
	verilator --binary --timing --assert --top-module mac_tb -f files.f -Mdir obj_dir
	./obj_dir/Vmac_tb +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	! grep -q "Test failures found" sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/mac_tb.sv */
`timescale 1ns/1ps

module mac_tb
	import mac_cfg_pkg::*;
	import mac_state_pkg::*;
();

	localparam int         N_SLOTS  = 4;
	localparam logic [3:0] CSR_BASE = 4'h0;

	logic              sys_clk  = 1'b0;
	logic              rst_n_i;
	logic [13:0]       csr_a_i;
	logic              csr_we_i;
	logic [DATA_W-1:0] csr_di_i;
	logic [DATA_W-1:0] csr_do_o;
	logic              irq_rx_o;
	logic [3:0]        phy_rx_data_i;
	logic              phy_dv_i;
	logic              phy_rx_er_i;
	logic [ADDR_W-1:0] wb_adr_o;
	logic              wb_cyc_o;
	logic              wb_stb_o;
	logic              wb_ack_i = 1'b0;
	logic [DATA_W-1:0] wb_dat_o;

	logic [31:0] mem [logic [31:0]]; // bus writes, by byte address.
	logic [7:0]  frame_buf [0:63];
	logic [31:0] frame_rng = 32'd78;
	logic [31:0] lat_rng   = 32'd78;
	logic        slow_ack  = 1'b0;   // 12 cycle ack for the overflow test.
	logic        in_flight = 1'b0;
	int          wait_left = 0;
	int          wr_count  = 0;
	int          cyc_cycles = 0;
	int          irq_cycles = 0;
	int          wr_mark;            // wr_count at frame start.
	int          errors   = 0;
	int          timeouts = 0;

	mac_top #(
		.N_SLOTS  (N_SLOTS),
		.CSR_BASE (CSR_BASE)
	) mac_top_i (
		.sys_clk       (sys_clk),
		.rst_n_i       (rst_n_i),
		.csr_a_i       (csr_a_i),
		.csr_we_i      (csr_we_i),
		.csr_di_i      (csr_di_i),
		.csr_do_o      (csr_do_o),
		.irq_rx_o      (irq_rx_o),
		.phy_rx_data_i (phy_rx_data_i),
		.phy_dv_i      (phy_dv_i),
		.phy_rx_er_i   (phy_rx_er_i),
		.wb_adr_o      (wb_adr_o),
		.wb_cyc_o      (wb_cyc_o),
		.wb_stb_o      (wb_stb_o),
		.wb_ack_i      (wb_ack_i),
		.wb_dat_o      (wb_dat_o)
	);

	always #2 sys_clk = ~sys_clk; // 4 ns period.

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ----------------------------------------------------------------------
	// bus slave and memory model, driven on the falling edge
	// ----------------------------------------------------------------------
	always @(negedge sys_clk) begin
		if (wb_cyc_o)
			cyc_cycles++;
		if (irq_rx_o)
			irq_cycles++;
		if (wb_ack_i) begin
			wb_ack_i  = 1'b0; // single cycle ack.
			in_flight = 1'b0;
		end else if (wb_cyc_o && wb_stb_o) begin
			if (!in_flight) begin
				in_flight = 1'b1;
				lat_rng   = xorshift32(lat_rng);
				wait_left = slow_ack ? 12 : int'(lat_rng[1:0]);
			end
			if (wait_left == 0) begin
				mem[wb_adr_o] = wb_dat_o;
				wr_count++;
				wb_ack_i = 1'b1;
			end else begin
				wait_left--;
			end
		end
	end

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// ----------------------------------------------------------------------
	// csr access
	// ----------------------------------------------------------------------
	task automatic csr_write(input int slot, input csr_field_e field, input logic [31:0] data);
		@(negedge sys_clk);
		csr_a_i  = {CSR_BASE, 10'(slot * 3 + int'(field))};
		csr_we_i = 1'b1;
		csr_di_i = data;
		@(negedge sys_clk);
		csr_we_i = 1'b0;
	endtask

	task automatic csr_read(input int slot, input csr_field_e field, output logic [31:0] data);
		@(negedge sys_clk);
		csr_a_i  = {CSR_BASE, 10'(slot * 3 + int'(field))};
		csr_we_i = 1'b0;
		@(negedge sys_clk);
		data = csr_do_o; // registered readback.
	endtask

	task automatic load_slot(input int slot, input logic [31:0] addr);
		csr_write(slot, FIELD_ADDR, addr);
		csr_write(slot, FIELD_STATE, 32'(SLOT_LOADED));
	endtask

	// ----------------------------------------------------------------------
	// mii frames
	// ----------------------------------------------------------------------
	task automatic random_len(output int len);
		frame_rng = xorshift32(frame_rng);
		len       = 9 + int'(frame_rng[4:0]); // 9 to 40 bytes.
	endtask

	task automatic fill_frame(input int len);
		for (int i = 0; i < len; i++) begin
			frame_rng    = xorshift32(frame_rng);
			frame_buf[i] = frame_rng[7:0];
		end
	endtask

	// er_nib < 0 sends a clean frame.
	task automatic send_frame(input int len, input int er_nib);
		wr_mark = wr_count;
		for (int n = 0; n < 2 * len; n++) begin
			@(negedge sys_clk);
			phy_dv_i      = 1'b1;
			phy_rx_data_i = n[0] ? frame_buf[n/2][7:4] : frame_buf[n/2][3:0]; // low first.
			phy_rx_er_i   = (n == er_nib);
		end
		@(negedge sys_clk);
		phy_dv_i      = 1'b0;
		phy_rx_er_i   = 1'b0;
		phy_rx_data_i = 4'h0;
	endtask

	// ----------------------------------------------------------------------
	// bounded waits
	// ----------------------------------------------------------------------
	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		while (irq_rx_o !== level && n < 200) begin
			@(negedge sys_clk);
			n++;
		end
		if (irq_rx_o !== level) begin
			$display("timeout: irq_rx_o never went to %0b", level);
			timeouts++;
		end
	endtask

	task automatic wait_bus_idle();
		int n;
		n = 0;
		while (wb_cyc_o && n < 100) begin
			@(negedge sys_clk);
			n++;
		end
		if (wb_cyc_o) begin
			$display("timeout: bus cycle never finished");
			timeouts++;
		end
	endtask

	task automatic wait_slot_state(input int slot, input slot_state_e st);
		logic [31:0] rd;
		int          n;
		n = 0;
		csr_read(slot, FIELD_STATE, rd);
		while (rd !== 32'(st) && n < 100) begin
			csr_read(slot, FIELD_STATE, rd);
			n++;
		end
		if (rd !== 32'(st)) begin
			$display("timeout: slot %0d never reached %s", slot, st.name());
			timeouts++;
		end
	endtask

	// memory words, count, state and irq of a completed frame.
	task automatic check_frame(input int slot, input logic [31:0] base, input int len);
		int          nwords;
		int          idx;
		logic [31:0] addr;
		logic [31:0] exp;
		logic [31:0] got;
		nwords = (len + 3) / 4;
		for (int w = 0; w < nwords; w++) begin
			for (int b = 0; b < 4; b++) begin
				idx           = w * 4 + b;
				exp[b*8 +: 8] = (idx < len) ? frame_buf[idx] : 8'h00; // zero pad.
			end
			addr = base + 32'(w * 4);
			got  = 'x;
			if (mem.exists(addr))
				got = mem[addr];
			expect_eq($sformatf("slot %0d word %0d", slot, w), got, exp);
		end
		expect_eq("bus writes", 32'(wr_count - wr_mark), 32'(nwords));
		csr_read(slot, FIELD_COUNT, got);
		expect_eq($sformatf("slot %0d count", slot), got, 32'(len));
		csr_read(slot, FIELD_STATE, got);
		expect_eq($sformatf("slot %0d state", slot), got, 32'(SLOT_PENDING));
		expect_eq("irq_rx_o", 32'(irq_rx_o), 32'd1);
	endtask

	initial begin
		logic [31:0] rd;
		int          len;
		int          mark;
		rst_n_i       = 1'b0;
		csr_a_i       = '0;
		csr_we_i      = 1'b0;
		csr_di_i      = '0;
		phy_rx_data_i = 4'h0;
		phy_dv_i      = 1'b0;
		phy_rx_er_i   = 1'b0;
		repeat (16) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n_i = 1'b1;

		// reset values and csr readback.
		expect_eq("csr_do_o after reset", csr_do_o, 32'd0);
		for (int s = 0; s < N_SLOTS; s++) begin
			csr_read(s, FIELD_STATE, rd);
			expect_eq($sformatf("slot %0d state after reset", s), rd, 32'(SLOT_EMPTY));
		end
		expect_eq("irq_rx_o after reset", 32'(irq_rx_o), 32'd0);
		csr_write(0, FIELD_ADDR, 32'h0000_1000);
		csr_read(0, FIELD_ADDR, rd);
		expect_eq("slot 0 addr", rd, 32'h0000_1000);
		csr_write(0, FIELD_STATE, 32'(SLOT_LOADED));
		csr_read(0, FIELD_STATE, rd);
		expect_eq("slot 0 state", rd, 32'(SLOT_LOADED));

		// random frame into slot 0, then release it.
		random_len(len);
		fill_frame(len);
		send_frame(len, -1);
		wait_irq(1'b1);
		check_frame(0, 32'h0000_1000, len);
		csr_write(0, FIELD_STATE, 32'(SLOT_EMPTY));
		wait_irq(1'b0);

		// lowest loaded slot first.
		load_slot(1, 32'h0000_2000);
		load_slot(3, 32'h0000_3000);
		random_len(len);
		fill_frame(len);
		send_frame(len, -1);
		wait_slot_state(1, SLOT_PENDING);
		check_frame(1, 32'h0000_2000, len);
		csr_read(3, FIELD_STATE, rd);
		expect_eq("slot 3 state after first frame", rd, 32'(SLOT_LOADED));
		random_len(len);
		fill_frame(len);
		send_frame(len, -1);
		wait_slot_state(3, SLOT_PENDING);
		check_frame(3, 32'h0000_3000, len);
		csr_write(1, FIELD_STATE, 32'(SLOT_EMPTY));
		csr_write(3, FIELD_STATE, 32'(SLOT_EMPTY));
		wait_irq(1'b0);

		// rx error mid-frame.
		load_slot(0, 32'h0000_4000);
		mark = irq_cycles;
		fill_frame(20);
		send_frame(20, 11);
		wait_bus_idle();
		csr_read(0, FIELD_STATE, rd);
		expect_eq("slot 0 state after rx error", rd, 32'(SLOT_LOADED));
		expect_eq("irq cycles after rx error", 32'(irq_cycles - mark), 32'd0);

		// no slot loaded, frame dropped.
		csr_write(0, FIELD_STATE, 32'(SLOT_EMPTY));
		mark = cyc_cycles;
		random_len(len);
		fill_frame(len);
		send_frame(len, -1);
		for (int s = 0; s < N_SLOTS; s++) begin
			csr_read(s, FIELD_STATE, rd);
			expect_eq($sformatf("slot %0d state after drop", s), rd, 32'(SLOT_EMPTY));
		end
		expect_eq("bus cycles during drop", 32'(cyc_cycles - mark), 32'd0);
		expect_eq("irq_rx_o after drop", 32'(irq_rx_o), 32'd0);

		// slow ack overflows the write buffer.
		load_slot(2, 32'h0000_5000);
		slow_ack = 1'b1;
		mark     = irq_cycles;
		fill_frame(24);
		send_frame(24, -1);
		wait_bus_idle();
		csr_read(2, FIELD_STATE, rd);
		expect_eq("slot 2 state after overflow", rd, 32'(SLOT_LOADED));
		expect_eq("irq cycles after overflow", 32'(irq_cycles - mark), 32'd0);
		slow_ack = 1'b0;
		csr_write(2, FIELD_ADDR, 32'h0000_6000); // fresh buffer.
		random_len(len);
		fill_frame(len);
		send_frame(len, -1);
		wait_irq(1'b1);
		check_frame(2, 32'h0000_6000, len);

		$display("checks failed: %0d, timeouts: %0d, assertion failures: %0d",
			errors, timeouts, mac_top_i.mac_asserts_i.fails);
		if (errors == 0 && timeouts == 0 && mac_top_i.mac_asserts_i.fails == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* bench/mac_asserts.sv */
`timescale 1ns/1ps

module mac_asserts
	import mac_cfg_pkg::*;
	import mac_state_pkg::*;
#(
	parameter int N_SLOTS = DEF_N_SLOTS
) (
	input logic                 sys_clk,
	input logic                 rst_n_i,
	input logic                 cyc_i,
	input logic                 stb_i,
	input logic                 ack_i,
	input logic [ADDR_W-1:0]    adr_i,
	input logic [DATA_W-1:0]    dat_i,
	input logic [N_SLOTS*2-1:0] slot_state_i
);

	int                 hold_fails   = 0;
	int                 stable_fails = 0;
	int                 reset_fails  = 0;
	int                 active_fails = 0;
	int                 fails;
	logic [N_SLOTS-1:0] active; // one bit per slot in SLOT_ACTIVE.

	assign fails = hold_fails + stable_fails + reset_fails + active_fails;

	always_comb begin
		for (int i = 0; i < N_SLOTS; i++)
			active[i] = (slot_state_e'(slot_state_i[i*2 +: 2]) == SLOT_ACTIVE);
	end

	// ----------------------------------------------------------------------
	// bus master protocol
	// ----------------------------------------------------------------------
	stb_held: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
		stb_i && !ack_i |=> stb_i)
		else begin
			$error("stb dropped before ack");
			hold_fails++;
		end

	bus_stable: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
		stb_i && !ack_i |=> $stable(adr_i) && $stable(dat_i))
		else begin
			$error("address or data changed while stb waited for ack");
			stable_fails++;
		end

	// cyc and stb both idle out of reset.
	bus_reset: assert property (@(posedge sys_clk)
		!rst_n_i |=> !cyc_i && !stb_i)
		else begin
			$error("cyc or stb high after reset");
			reset_fails++;
		end

	// ----------------------------------------------------------------------
	// slot usage
	// ----------------------------------------------------------------------
	one_active: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
		$onehot0(active))
		else begin
			$error("more than one slot active");
			active_fails++;
		end

endmodule

bind mac_top mac_asserts #(
	.N_SLOTS (N_SLOTS)
) mac_asserts_i (
	.sys_clk      (sys_clk),
	.rst_n_i      (rst_n_i),
	.cyc_i        (wb_cyc_o),
	.stb_i        (wb_stb_o),
	.ack_i        (wb_ack_i),
	.adr_i        (wb_adr_o),
	.dat_i        (wb_dat_o),
	.slot_state_i (slot_state)
);

/* hdl/mac_top.sv */
`timescale 1ns/1ps

module mac_top
	import mac_cfg_pkg::*;
#(
	parameter int         N_SLOTS  = DEF_N_SLOTS,
	parameter logic [3:0] CSR_BASE = DEF_CSR_BASE
) (
	input  logic              sys_clk,
	input  logic              rst_n_i,

	input  logic [13:0]       csr_a_i,
	input  logic              csr_we_i,
	input  logic [DATA_W-1:0] csr_di_i,
	output logic [DATA_W-1:0] csr_do_o,
	output logic              irq_rx_o,

	input  logic [3:0]        phy_rx_data_i,
	input  logic              phy_dv_i,
	input  logic              phy_rx_er_i,

	output logic [ADDR_W-1:0] wb_adr_o,
	output logic              wb_cyc_o,
	output logic              wb_stb_o,
	input  logic              wb_ack_i,
	output logic [DATA_W-1:0] wb_dat_o
);

	// slot views, packed per slot.
	logic [N_SLOTS*2-1:0]      slot_state;
	logic [N_SLOTS*ADDR_W-1:0] slot_addr;
	logic [N_SLOTS*CNT_W-1:0]  slot_count;

	// csr to slots.
	logic [N_SLOTS-1:0] state_we;
	logic [N_SLOTS-1:0] addr_we;
	logic [DATA_W-1:0]  wdata;

	// selector to slots.
	logic [N_SLOTS-1:0] claim;
	logic [N_SLOTS-1:0] incr;
	logic [N_SLOTS-1:0] done;
	logic [N_SLOTS-1:0] abort;

	// engine and selector.
	logic              frame_start;
	logic              byte_incr;
	logic              frame_end;
	logic              frame_abort;
	logic              slot_ok;
	logic [ADDR_W-1:0] buf_addr;

	mac_csr #(
		.N_SLOTS  (N_SLOTS),
		.CSR_BASE (CSR_BASE)
	) mac_csr_i (
		.sys_clk      (sys_clk),
		.rst_n_i      (rst_n_i),
		.csr_a_i      (csr_a_i),
		.csr_we_i     (csr_we_i),
		.csr_di_i     (csr_di_i),
		.csr_do_o     (csr_do_o),
		.slot_state_i (slot_state),
		.slot_addr_i  (slot_addr),
		.slot_count_i (slot_count),
		.state_we_o   (state_we),
		.addr_we_o    (addr_we),
		.wdata_o      (wdata),
		.irq_rx_o     (irq_rx_o)
	);

	// ----------------------------------------------------------------------
	// receive slots
	// ----------------------------------------------------------------------
	for (genvar g = 0; g < N_SLOTS; g++) begin : g_slot
		mac_rx_slot mac_rx_slot_i (
			.sys_clk    (sys_clk),
			.rst_n_i    (rst_n_i),
			.state_we_i (state_we[g]),
			.addr_we_i  (addr_we[g]),
			.wdata_i    (wdata),
			.claim_i    (claim[g]),
			.incr_i     (incr[g]),
			.done_i     (done[g]),
			.abort_i    (abort[g]),
			.state_o    (slot_state[g*2 +: 2]),
			.addr_o     (slot_addr[g*ADDR_W +: ADDR_W]),
			.count_o    (slot_count[g*CNT_W +: CNT_W])
		);
	end

	mac_rx_sel #(
		.N_SLOTS (N_SLOTS)
	) mac_rx_sel_i (
		.sys_clk       (sys_clk),
		.rst_n_i       (rst_n_i),
		.slot_state_i  (slot_state),
		.slot_addr_i   (slot_addr),
		.frame_start_i (frame_start),
		.byte_incr_i   (byte_incr),
		.frame_end_i   (frame_end),
		.frame_abort_i (frame_abort),
		.claim_o       (claim),
		.incr_o        (incr),
		.done_o        (done),
		.abort_o       (abort),
		.slot_ok_o     (slot_ok),
		.buf_addr_o    (buf_addr)
	);

	mac_rx_dma mac_rx_dma_i (
		.sys_clk       (sys_clk),
		.rst_n_i       (rst_n_i),
		.phy_rx_data_i (phy_rx_data_i),
		.phy_dv_i      (phy_dv_i),
		.phy_rx_er_i   (phy_rx_er_i),
		.slot_ok_i     (slot_ok),
		.buf_addr_i    (buf_addr),
		.frame_start_o (frame_start),
		.byte_incr_o   (byte_incr),
		.frame_end_o   (frame_end),
		.frame_abort_o (frame_abort),
		.adr_o         (wb_adr_o),
		.cyc_o         (wb_cyc_o),
		.stb_o         (wb_stb_o),
		.ack_i         (wb_ack_i),
		.wdat_o        (wb_dat_o)
	);

endmodule

/* hdl/mac_rx_dma.sv */
`timescale 1ns/1ps

module mac_rx_dma
	import mac_cfg_pkg::*;
	import mac_state_pkg::*;
(
	input  logic              sys_clk,
	input  logic              rst_n_i,

	// mii receive, synchronous to sys_clk.
	input  logic [3:0]        phy_rx_data_i,
	input  logic              phy_dv_i,
	input  logic              phy_rx_er_i,

	input  logic              slot_ok_i,
	input  logic [ADDR_W-1:0] buf_addr_i,

	output logic              frame_start_o,
	output logic              byte_incr_o,
	output logic              frame_end_o,
	output logic              frame_abort_o,

	// bus master, write only, all byte lanes.
	output logic [ADDR_W-1:0] adr_o,
	output logic              cyc_o,
	output logic              stb_o,
	input  logic              ack_i,
	output logic [DATA_W-1:0] wdat_o
);

	rx_state_e         state_q;
	logic              dv_q;
	logic              first_q;  // first cycle after start.
	logic              bus_req;  // write in flight.
	logic              bus_free; // buffer free this cycle.
	logic              ovf;      // word done, buffer busy.
	logic [2:0]        nib_cnt;
	logic [DATA_W-1:0] word_q;
	logic [DATA_W-1:0] word_nxt;
	logic [ADDR_W-1:0] next_adr;

	assign bus_free      = !bus_req || ack_i;
	assign ovf           = (nib_cnt == 3'd7) && !bus_free;
	assign frame_start_o = (state_q == RX_IDLE) && phy_dv_i && !dv_q;
	assign cyc_o         = bus_req;
	assign stb_o         = bus_req; // rise and fall together.

	// low nibble first.
	always_comb begin
		word_nxt = word_q;
		word_nxt[{nib_cnt, 2'b00} +: 4] = phy_rx_data_i;
	end

	// ----------------------------------------------------------------------
	// receive fsm and bus master
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			state_q       <= RX_IDLE;
			dv_q          <= 1'b0;
			first_q       <= 1'b0;
			bus_req       <= 1'b0;
			nib_cnt       <= '0;
			byte_incr_o   <= 1'b0;
			frame_end_o   <= 1'b0;
			frame_abort_o <= 1'b0;
		end else begin
			dv_q          <= phy_dv_i;
			first_q       <= 1'b0;
			byte_incr_o   <= 1'b0;
			frame_end_o   <= 1'b0;
			frame_abort_o <= 1'b0;
			if (bus_req && ack_i)
				bus_req <= 1'b0; // issue below may re-arm.
			case (state_q)
				RX_IDLE: begin
					if (phy_dv_i) begin
						if (dv_q) begin
							state_q <= RX_DROP; // caught mid-frame.
						end else begin
							word_q  <= {{(DATA_W-4){1'b0}}, phy_rx_data_i};
							nib_cnt <= 3'd1;
							first_q <= 1'b1;
							state_q <= RX_RECV;
						end
					end
				end
				RX_RECV: begin
					if (first_q)
						next_adr <= buf_addr_i; // grant valid now.
					if (first_q && !slot_ok_i) begin
						state_q <= RX_DROP; // no slot, no bus traffic.
					end else if (!phy_dv_i) begin
						state_q <= RX_FLUSH;
					end else if (phy_rx_er_i || ovf) begin
						frame_abort_o <= 1'b1;
						state_q       <= RX_DROP;
					end else begin
						byte_incr_o <= nib_cnt[0]; // every second nibble.
						nib_cnt     <= nib_cnt + 3'd1;
						if (nib_cnt == 3'd7) begin
							bus_req  <= 1'b1; // word out next cycle.
							wdat_o   <= word_nxt;
							adr_o    <= next_adr;
							next_adr <= next_adr + ADDR_W'(4);
							word_q   <= '0;
						end else begin
							word_q <= word_nxt;
						end
					end
				end
				RX_FLUSH: begin
					if (bus_free) begin
						if (nib_cnt != 3'd0) begin
							// partial word, upper nibbles already zero.
							bus_req  <= 1'b1;
							wdat_o   <= word_q;
							adr_o    <= next_adr;
							next_adr <= next_adr + ADDR_W'(4);
							nib_cnt  <= '0;
						end else begin
							frame_end_o <= 1'b1; // last ack seen.
							state_q     <= RX_IDLE;
						end
					end
				end
				RX_DROP: begin
					if (!phy_dv_i)
						state_q <= RX_IDLE;
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

endmodule

/* hdl/mac_rx_sel.sv */
`timescale 1ns/1ps

module mac_rx_sel
	import mac_cfg_pkg::*;
	import mac_state_pkg::*;
#(
	parameter int N_SLOTS = DEF_N_SLOTS
) (
	input  logic                      sys_clk,
	input  logic                      rst_n_i,

	input  logic [N_SLOTS*2-1:0]      slot_state_i,
	input  logic [N_SLOTS*ADDR_W-1:0] slot_addr_i,

	input  logic                      frame_start_i,
	input  logic                      byte_incr_i,
	input  logic                      frame_end_i,
	input  logic                      frame_abort_i,

	output logic [N_SLOTS-1:0]        claim_o,
	output logic [N_SLOTS-1:0]        incr_o,
	output logic [N_SLOTS-1:0]        done_o,
	output logic [N_SLOTS-1:0]        abort_o,
	output logic                      slot_ok_o,
	output logic [ADDR_W-1:0]         buf_addr_o
);

	localparam int IDX_W = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1;

	logic             found;   // some slot loaded.
	logic [IDX_W-1:0] pick;    // lowest loaded slot.
	logic [IDX_W-1:0] grant_q;
	logic             claim_q; // claim one cycle after start.

	// priority scan, downward so the lowest index is kept.
	always_comb begin
		found = 1'b0;
		pick  = '0;
		for (int i = N_SLOTS - 1; i >= 0; i--) begin
			if (slot_state_e'(slot_state_i[i*2 +: 2]) == SLOT_LOADED) begin
				found = 1'b1;
				pick  = IDX_W'(i);
			end
		end
	end

	// ----------------------------------------------------------------------
	// grant register
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			slot_ok_o <= 1'b0;
			claim_q   <= 1'b0;
		end else begin
			claim_q <= frame_start_i && found;
			if (frame_start_i)
				slot_ok_o <= found;
			else if (frame_end_i || frame_abort_i)
				slot_ok_o <= 1'b0; // frame over.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (frame_start_i)
			grant_q <= pick;
	end

	// event steering, granted slot only.
	always_comb begin
		for (int i = 0; i < N_SLOTS; i++) begin
			claim_o[i] = claim_q && (grant_q == IDX_W'(i));
			incr_o[i]  = slot_ok_o && byte_incr_i && (grant_q == IDX_W'(i));
			done_o[i]  = slot_ok_o && frame_end_i && (grant_q == IDX_W'(i));
			abort_o[i] = slot_ok_o && frame_abort_i && (grant_q == IDX_W'(i));
		end
	end

	assign buf_addr_o = slot_addr_i[grant_q*ADDR_W +: ADDR_W];

endmodule

/* hdl/mac_rx_slot.sv */
`timescale 1ns/1ps

module mac_rx_slot
	import mac_cfg_pkg::*;
	import mac_state_pkg::*;
(
	input  logic              sys_clk,
	input  logic              rst_n_i,

	// sw side.
	input  logic              state_we_i,
	input  logic              addr_we_i,
	input  logic [DATA_W-1:0] wdata_i,

	// receive engine side, already steered to this slot.
	input  logic              claim_i,
	input  logic              incr_i,
	input  logic              done_i,
	input  logic              abort_i,

	output slot_state_e       state_o,
	output logic [ADDR_W-1:0] addr_o,
	output logic [CNT_W-1:0]  count_o
);

	slot_state_e sw_state;
	logic        sw_ok; // legal sw state write.

	assign sw_state = slot_state_e'(wdata_i[1:0]);
	assign sw_ok    = state_we_i && ((sw_state == SLOT_EMPTY) || (sw_state == SLOT_LOADED));

	// ----------------------------------------------------------------------
	// slot fsm
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			state_o <= SLOT_EMPTY;
		end else begin
			case (state_o)
				SLOT_LOADED: begin
					if (claim_i)
						state_o <= SLOT_ACTIVE; // frame wins over sw.
					else if (sw_ok)
						state_o <= sw_state;
				end
				SLOT_ACTIVE: begin
					// sw locked out while receiving.
					if (abort_i)
						state_o <= SLOT_LOADED; // buffer reused.
					else if (done_i)
						state_o <= SLOT_PENDING;
				end
				default: begin
					if (sw_ok)
						state_o <= sw_state; // empty or pending.
				end
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// buffer address and byte count
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (addr_we_i && (state_o != SLOT_ACTIVE))
			addr_o <= wdata_i;
		if (claim_i && (state_o == SLOT_LOADED))
			count_o <= '0; // new frame.
		else if (incr_i && (state_o == SLOT_ACTIVE))
			count_o <= count_o + 1'b1;
	end

endmodule

/* hdl/mac_csr.sv */
`timescale 1ns/1ps

module mac_csr
	import mac_cfg_pkg::*;
	import mac_state_pkg::*;
#(
	parameter int         N_SLOTS  = DEF_N_SLOTS,
	parameter logic [3:0] CSR_BASE = DEF_CSR_BASE
) (
	input  logic                       sys_clk,
	input  logic                       rst_n_i,

	input  logic [13:0]                csr_a_i,
	input  logic                       csr_we_i,
	input  logic [DATA_W-1:0]          csr_di_i,
	output logic [DATA_W-1:0]          csr_do_o,

	input  logic [N_SLOTS*2-1:0]       slot_state_i,
	input  logic [N_SLOTS*ADDR_W-1:0]  slot_addr_i,
	input  logic [N_SLOTS*CNT_W-1:0]   slot_count_i,

	output logic [N_SLOTS-1:0]         state_we_o,
	output logic [N_SLOTS-1:0]         addr_we_o,
	output logic [DATA_W-1:0]          wdata_o,
	output logic                       irq_rx_o
);

	logic              sel;      // base matches.
	logic [9:0]        reg_idx;
	logic [9:0]        slot_num;
	csr_field_e        field;
	logic              slot_hit; // base matches and slot exists.
	logic [DATA_W-1:0] rd_data;
	logic              any_pending;

	// ----------------------------------------------------------------------
	// address decode
	// ----------------------------------------------------------------------
	assign sel      = (csr_a_i[13:10] == CSR_BASE);
	assign reg_idx  = csr_a_i[9:0];
	assign slot_num = reg_idx / 10'd3;
	assign field    = csr_field_e'(2'(reg_idx % 10'd3));
	assign slot_hit = sel && (slot_num < 10'(N_SLOTS));

	assign wdata_o = csr_di_i; // shared by all slots.

	// strobes, readback and pending scan.
	always_comb begin
		state_we_o  = '0;
		addr_we_o   = '0;
		rd_data     = '0; // unselected reads as zero.
		any_pending = 1'b0;
		for (int i = 0; i < N_SLOTS; i++) begin
			if (slot_hit && (slot_num == 10'(i))) begin
				state_we_o[i] = csr_we_i && (field == FIELD_STATE);
				addr_we_o[i]  = csr_we_i && (field == FIELD_ADDR); // count writes dropped.
				case (field)
					FIELD_STATE: rd_data = DATA_W'(slot_state_i[i*2 +: 2]);
					FIELD_ADDR:  rd_data = slot_addr_i[i*ADDR_W +: ADDR_W];
					FIELD_COUNT: rd_data = DATA_W'(slot_count_i[i*CNT_W +: CNT_W]);
					default:     rd_data = '0;
				endcase
			end
			if (slot_state_e'(slot_state_i[i*2 +: 2]) == SLOT_PENDING)
				any_pending = 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// registered outputs
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			csr_do_o <= '0;
			irq_rx_o <= 1'b0;
		end else begin
			csr_do_o <= rd_data;     // one cycle after the address.
			irq_rx_o <= any_pending; // level, any slot pending.
		end
	end

endmodule

/* hdl/mac_state_pkg.sv */
// state encodings of the receive slots and the receive engine.
package mac_state_pkg;

	// slot life cycle, visible to sw through FIELD_STATE.
	typedef enum logic [1:0] {
		SLOT_EMPTY   = 2'd0, // no buffer.
		SLOT_LOADED  = 2'd1, // buffer ready for a frame.
		SLOT_ACTIVE  = 2'd2, // receiving.
		SLOT_PENDING = 2'd3  // frame done, waiting for sw.
	} slot_state_e;

	// receive engine.
	typedef enum logic [1:0] {
		RX_IDLE,  // wait for dv.
		RX_RECV,  // packing nibbles.
		RX_FLUSH, // last partial word and final ack.
		RX_DROP   // discard until dv falls.
	} rx_state_e;

endpackage

/* hdl/mac_cfg_pkg.sv */
// bus and csr layout shared by the receive path.
package mac_cfg_pkg;

	// ----------------------------------------------------------------------
	// bus widths
	// ----------------------------------------------------------------------
	localparam int ADDR_W = 32; // byte address.
	localparam int DATA_W = 32; // one word per bus cycle.
	localparam int CNT_W  = 11; // byte count, frames up to 2047 bytes.

	// ----------------------------------------------------------------------
	// csr map
	// ----------------------------------------------------------------------
	// register index i*3+field selects one field of slot i.
	typedef enum logic [1:0] {
		FIELD_STATE = 2'd0, // slot state, sw writes empty or loaded.
		FIELD_ADDR  = 2'd1, // buffer base address.
		FIELD_COUNT = 2'd2  // received byte count, read only.
	} csr_field_e;

	// defaults for the top level.
	localparam int         DEF_N_SLOTS  = 4;
	localparam logic [3:0] DEF_CSR_BASE = 4'h0;

endpackage
